//--- capture/pixel_capture.sv
`timescale 1ns/100ps

module pixel_capture
  import cam_pkg::*;
#(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  logic        clk_camera,
  input  logic        recent_reset,
  input  logic [7:0]  cam_data_i,
  input  logic        cam_pclk_i,
  input  logic        cam_hsync_i,
  input  logic        cam_vsync_i,
  output pixel_word_u cap_pixel_o,
  output logic        cap_valid_o,
  output logic        cap_last_o
);

  // ========================================================================
  // two-flop synchronizers on the raw camera bus
  // ========================================================================

  logic [7:0] data_s1;
  logic [7:0] data_s2;
  logic       pclk_s1;
  logic       pclk_s2;
  logic       hsync_s1;
  logic       hsync_s2;
  logic       vsync_s1;
  logic       vsync_s2;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_s1  <= 1'b0;
      pclk_s2  <= 1'b0;
      hsync_s1 <= 1'b0;
      hsync_s2 <= 1'b0;
      vsync_s1 <= 1'b0;
      vsync_s2 <= 1'b0;
    end else begin
      pclk_s1  <= cam_pclk_i;
      pclk_s2  <= pclk_s1;
      hsync_s1 <= cam_hsync_i;
      hsync_s2 <= hsync_s1;
      vsync_s1 <= cam_vsync_i;
      vsync_s2 <= vsync_s1;
    end
  end

  // data bits only travel with the strobes
  always_ff @(posedge clk_camera) begin
    data_s1 <= cam_data_i;
    data_s2 <= data_s1;
  end

  // ========================================================================
  // edge register: pclk rise, hsync fall, bus levels aligned to them
  // ========================================================================

  logic       pclk_q;
  logic       pclk_rise;
  logic       hsync_q;
  logic       hsync_fall;
  logic       vsync_q;
  logic [7:0] data_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_q     <= 1'b0;
      pclk_rise  <= 1'b0;
      hsync_q    <= 1'b0;
      hsync_fall <= 1'b0;
      vsync_q    <= 1'b0;
    end else begin
      pclk_q     <= pclk_s2;
      pclk_rise  <= pclk_s2 & ~pclk_q;
      // hsync_q still holds the old level here
      hsync_fall <= hsync_q & ~hsync_s2;
      hsync_q    <= hsync_s2;
      vsync_q    <= vsync_s2;
    end
  end

  always_ff @(posedge clk_camera) begin
    data_q <= data_s2;
  end

  // ========================================================================
  // byte pairing and position counters
  // ========================================================================

  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;
  logic                lo_phase;
  logic [7:0]          hi_byte_q;
  logic                take_byte;
  logic                pixel_done;
  logic                last_pos;

  // a byte counts only inside an active line and outside blanking
  assign take_byte  = pclk_rise & hsync_q & ~vsync_q;
  assign pixel_done = take_byte & lo_phase;

  // final pixel of the frame
  assign last_pos = (hcount == HCOUNT_W'(FRAME_WIDTH - 1)) &&
                    (vcount == VCOUNT_W'(FRAME_HEIGHT - 1));

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      hcount      <= '0;
      vcount      <= '0;
      lo_phase    <= 1'b0;
      cap_valid_o <= 1'b0;
      cap_last_o  <= 1'b0;
    end else begin
      // single-cycle strobe
      cap_valid_o <= 1'b0;
      cap_last_o  <= 1'b0;
      if (vsync_q) begin
        // vertical blanking restarts everything
        hcount   <= '0;
        vcount   <= '0;
        lo_phase <= 1'b0;
      end else if (hsync_fall) begin
        hcount <= '0;
        vcount <= vcount + 1'b1;
      end else if (pixel_done) begin
        lo_phase    <= 1'b0;
        cap_valid_o <= 1'b1;
        cap_last_o  <= last_pos;
        hcount      <= hcount + 1'b1;
      end else if (take_byte) begin
        lo_phase <= 1'b1;
      end
    end
  end

  // payload path, written through the byte view
  always_ff @(posedge clk_camera) begin
    if (take_byte && !lo_phase) begin
      hi_byte_q <= data_q;
    end
    if (pixel_done) begin
      cap_pixel_o.bytes.hi_byte <= hi_byte_q;
      cap_pixel_o.bytes.lo_byte <= data_q;
    end
  end

endmodule

//--- common/cam_pkg.sv
// ==========================================================================
// shared widths and the pixel word for the camera capture path
// ==========================================================================

package cam_pkg;

  // one RGB565 pixel
  localparam int PIXEL_W = 16;

  // pixels packed into one memory chunk
  localparam int PIXELS_PER_CHUNK = 8;

  // chunk width as seen by the memory writer
  localparam int CHUNK_W = PIXEL_W * PIXELS_PER_CHUNK;

  // slot counter width inside the stacker
  localparam int SLOT_W = $clog2(PIXELS_PER_CHUNK);

  // position counters, sized for 1280 x 720
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // the pixel word, decoded two ways
  // capture writes it byte by byte, the key stage reads colours
  typedef union packed {
    // first byte on the bus lands in hi_byte
    struct packed {
      logic [7:0] hi_byte;
      logic [7:0] lo_byte;
    } bytes;
    // RGB565 colour fields
    struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
    } rgb;
  } pixel_word_u;

endpackage

//--- run_sim.sh
#!/bin/sh
# build the camera capture testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module camera_capture_tb \
  -f sources.f -o camera_capture_sim \
  && ./obj_dir/camera_capture_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sources.f
common/cam_pkg.sv
capture/pixel_capture.sv
src/chroma_key.sv
stacker/chunk_stacker.sv
src/camera_capture_top.sv
test/camera_capture_assertions.sv
test/camera_capture_tb.sv

//--- src/camera_capture_top.sv
`timescale 1ns/100ps

module camera_capture_top
  import cam_pkg::*;
#(
  parameter int                 FRAME_WIDTH  = 1280,
  parameter int                 FRAME_HEIGHT = 720,
  parameter int                 KEY_LOW      = 0,
  parameter int                 KEY_HIGH     = 64,
  parameter logic [PIXEL_W-1:0] KEY_FILL     = 16'h2277
) (
  input  logic               clk_camera,
  input  logic               recent_reset,
  // parallel camera bus
  input  logic [7:0]         cam_data_i,
  input  logic               cam_pclk_i,
  input  logic               cam_hsync_i,
  input  logic               cam_vsync_i,
  // chunk stream to the memory writer
  output logic [CHUNK_W-1:0] chunk_data_o,
  output logic               chunk_valid_o,
  output logic               chunk_last_o,
  input  logic               chunk_ready_i,
  output logic               overflow_o
);

  // ========================================================================
  // capture -> key -> stacker, all push-only until the chunk output
  // ========================================================================

  pixel_word_u cap_pixel;
  logic        cap_valid;
  logic        cap_last;

  pixel_word_u key_pixel;
  logic        key_valid;
  logic        key_last;

  // bus sync, byte pairing, position tracking
  pixel_capture #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT)
  ) capture_i (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_data_i   (cam_data_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .cap_pixel_o  (cap_pixel),
    .cap_valid_o  (cap_valid),
    .cap_last_o   (cap_last)
  );

  // green-screen substitution
  chroma_key #(
    .KEY_LOW      (KEY_LOW),
    .KEY_HIGH     (KEY_HIGH),
    .KEY_FILL     (KEY_FILL)
  ) key_i (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cap_pixel_i  (cap_pixel),
    .cap_valid_i  (cap_valid),
    .cap_last_i   (cap_last),
    .key_pixel_o  (key_pixel),
    .key_valid_o  (key_valid),
    .key_last_o   (key_last)
  );

  // eight pixels per 128-bit chunk
  chunk_stacker stacker_i (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .key_pixel_i   (key_pixel),
    .key_valid_i   (key_valid),
    .key_last_i    (key_last),
    .chunk_ready_i (chunk_ready_i),
    .chunk_data_o  (chunk_data_o),
    .chunk_valid_o (chunk_valid_o),
    .chunk_last_o  (chunk_last_o),
    .overflow_o    (overflow_o)
  );

endmodule

//--- src/chroma_key.sv
`timescale 1ns/100ps

module chroma_key
  import cam_pkg::*;
#(
  parameter int                 KEY_LOW  = 0,
  parameter int                 KEY_HIGH = 64,
  parameter logic [PIXEL_W-1:0] KEY_FILL = 16'h2277
) (
  input  logic        clk_camera,
  input  logic        recent_reset,
  input  pixel_word_u cap_pixel_i,
  input  logic        cap_valid_i,
  input  logic        cap_last_i,
  output pixel_word_u key_pixel_o,
  output logic        key_valid_o,
  output logic        key_last_o
);

  // window bounds in the 8-bit green domain
  localparam logic [7:0] KEY_LOW_B  = 8'(KEY_LOW);
  localparam logic [7:0] KEY_HIGH_B = 8'(KEY_HIGH);

  logic [7:0] green_8;
  logic       in_window;

  // 6-bit green widened by two zero bits
  assign green_8 = {cap_pixel_i.rgb.green, 2'b00};

  // inclusive on both ends
  assign in_window = (green_8 >= KEY_LOW_B) && (green_8 <= KEY_HIGH_B);

  // strobes follow the data by one cycle
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      key_valid_o <= 1'b0;
      key_last_o  <= 1'b0;
    end else begin
      key_valid_o <= cap_valid_i;
      key_last_o  <= cap_valid_i & cap_last_i;
    end
  end

  // keyed pixels become the fill colour
  always_ff @(posedge clk_camera) begin
    if (cap_valid_i) begin
      if (in_window) begin
        key_pixel_o <= KEY_FILL;
      end else begin
        key_pixel_o <= cap_pixel_i;
      end
    end
  end

endmodule

//--- stacker/chunk_stacker.sv
`timescale 1ns/100ps

module chunk_stacker
  import cam_pkg::*;
(
  input  logic               clk_camera,
  input  logic               recent_reset,
  input  pixel_word_u        key_pixel_i,
  input  logic               key_valid_i,
  input  logic               key_last_i,
  input  logic               chunk_ready_i,
  output logic [CHUNK_W-1:0] chunk_data_o,
  output logic               chunk_valid_o,
  output logic               chunk_last_o,
  output logic               overflow_o
);

  // ========================================================================
  // assembly side
  // ========================================================================

  logic [CHUNK_W-1:0] asm_q;
  logic [CHUNK_W-1:0] asm_next;
  logic [SLOT_W-1:0]  slot;
  logic               asm_last;
  logic               chunk_done;
  logic               done_last;

  // new pixel enters at the top, so pixel 0 ends up in the low bits
  assign asm_next = {key_pixel_i, asm_q[CHUNK_W-1:PIXEL_W]};

  // eighth pixel closes the chunk
  assign chunk_done = key_valid_i && (slot == SLOT_W'(PIXELS_PER_CHUNK - 1));
  assign done_last  = asm_last | key_last_i;

  always_ff @(posedge clk_camera) begin
    if (key_valid_i) begin
      asm_q <= asm_next;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      slot     <= '0;
      asm_last <= 1'b0;
    end else if (key_valid_i) begin
      // wraps to zero after the eighth pixel
      slot <= slot + 1'b1;
      if (chunk_done) begin
        asm_last <= 1'b0;
      end else if (key_last_i) begin
        asm_last <= 1'b1;
      end
    end
  end

  // ========================================================================
  // output register, one chunk deep
  // ========================================================================

  logic out_free;

  // empty now, or emptied by a transfer this cycle
  assign out_free = ~chunk_valid_o | chunk_ready_i;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      chunk_valid_o <= 1'b0;
      chunk_last_o  <= 1'b0;
      overflow_o    <= 1'b0;
    end else begin
      if (chunk_done && out_free) begin
        chunk_valid_o <= 1'b1;
        chunk_last_o  <= done_last;
      end else if (chunk_valid_o && chunk_ready_i) begin
        chunk_valid_o <= 1'b0;
        chunk_last_o  <= 1'b0;
      end
      // held chunk wins, the newer one is lost
      if (chunk_done && !out_free) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // data only moves on a load, so it stays put while waiting
  always_ff @(posedge clk_camera) begin
    if (chunk_done && out_free) begin
      chunk_data_o <= asm_next;
    end
  end

endmodule

//--- test/camera_capture_assertions.sv
`timescale 1ns/100ps

module camera_capture_assertions
  import cam_pkg::*;
(
  input logic               clk_camera,
  input logic               recent_reset,
  input logic [CHUNK_W-1:0] chunk_data_i,
  input logic               chunk_valid_i,
  input logic               chunk_last_i,
  input logic               chunk_ready_i,
  input logic               overflow_i
);

  // failures seen so far
  int unsigned fail_count = 0;

  // ==========================================================================
  // output stream handshake
  // ==========================================================================

  // a waiting chunk keeps valid, data and last until it is taken
  hold_until_ready: assert property (@(posedge clk_camera) disable iff (recent_reset)
    chunk_valid_i && !chunk_ready_i |=>
      chunk_valid_i && $stable(chunk_data_i) && $stable(chunk_last_i))
    else begin
      fail_count++;
      $error("chunk dropped or changed while waiting for ready");
    end

  // last never appears on its own
  last_with_valid: assert property (@(posedge clk_camera) disable iff (recent_reset)
    chunk_last_i |-> chunk_valid_i)
    else begin
      fail_count++;
      $error("chunk last high without chunk valid");
    end

  // sticky until reset
  overflow_sticky: assert property (@(posedge clk_camera) disable iff (recent_reset)
    overflow_i |=> overflow_i)
    else begin
      fail_count++;
      $error("overflow flag fell without reset");
    end

endmodule

bind chunk_stacker camera_capture_assertions assertions_i (
  .clk_camera    (clk_camera),
  .recent_reset  (recent_reset),
  .chunk_data_i  (chunk_data_o),
  .chunk_valid_i (chunk_valid_o),
  .chunk_last_i  (chunk_last_o),
  .chunk_ready_i (chunk_ready_i),
  .overflow_i    (overflow_o)
);

//--- test/camera_capture_tb.sv
`timescale 1ns/100ps

module camera_capture_tb;

  // ==========================================================================
  // frame geometry and key window, small frame keeps the run short
  // ==========================================================================

  localparam int          FRAME_WIDTH      = 16;
  localparam int          FRAME_HEIGHT     = 4;
  localparam int          FRAME_PIXELS     = FRAME_WIDTH * FRAME_HEIGHT;
  localparam int          CHUNKS_PER_FRAME = FRAME_PIXELS / 8;
  localparam int          KEY_LOW          = 0;
  localparam int          KEY_HIGH         = 64;
  localparam logic [15:0] KEY_FILL         = 16'h2277;
  localparam logic [31:0] SEED             = 32'hff8971ad;
  // two random frames, directed, ready toggling, ready stalled
  localparam int          NUM_FRAMES       = 5;
  // twice the frame time at 16 clocks per pixel and 10 ns per clock
  localparam int          TIMEOUT_NS       = 2 * NUM_FRAMES * FRAME_PIXELS * 16 * 10;
  // ready driver modes
  localparam int          READY_HIGH       = 0;
  localparam int          READY_RANDOM     = 1;
  localparam int          READY_LOW        = 2;

  logic         clk_camera = 1'b0;
  logic         recent_reset;
  logic [7:0]   cam_data_i;
  logic         cam_pclk_i;
  logic         cam_hsync_i;
  logic         cam_vsync_i;
  logic [127:0] chunk_data_o;
  logic         chunk_valid_o;
  logic         chunk_last_o;
  logic         chunk_ready_i;
  logic         overflow_o;

  // pixels of the frame on the bus, hi byte first
  logic [15:0]  frame_pix [FRAME_PIXELS];
  logic [127:0] exp_data_q [$];
  logic         exp_last_q [$];
  logic [127:0] exp_data;
  logic         exp_last;
  logic [31:0]  byte_state  = SEED;
  logic [31:0]  ready_state = SEED;
  int           ready_mode  = READY_HIGH;
  int           ready_left  = 0;

  camera_capture_top #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT),
    .KEY_LOW      (KEY_LOW),
    .KEY_HIGH     (KEY_HIGH),
    .KEY_FILL     (KEY_FILL)
  ) dut_i (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_data_i    (cam_data_i),
    .cam_pclk_i    (cam_pclk_i),
    .cam_hsync_i   (cam_hsync_i),
    .cam_vsync_i   (cam_vsync_i),
    .chunk_data_o  (chunk_data_o),
    .chunk_valid_o (chunk_valid_o),
    .chunk_last_o  (chunk_last_o),
    .chunk_ready_i (chunk_ready_i),
    .overflow_o    (overflow_o)
  );

  // 100 MHz camera-side clock
  always #5 clk_camera = ~clk_camera;

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before all chunks arrived");
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  // ==========================================================================
  // helpers: random source, reference model, check
  // ==========================================================================

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected chunk from eight bus pixels: key rule, then pixel n at bits 16n
  function automatic logic [127:0] ref_chunk(input int base);
    logic [127:0] chunk;
    logic [15:0]  pix;
    int           green_8;
    chunk = '0;
    for (int n = 0; n < 8; n++) begin
      pix = frame_pix[base + n];
      // green sits in bits 10..5, widened with two zeros
      green_8 = int'({pix[10:5], 2'b00});
      if (green_8 >= KEY_LOW && green_8 <= KEY_HIGH) begin
        pix = KEY_FILL;
      end
      chunk[16*n +: 16] = pix;
    end
    return chunk;
  endfunction

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // ==========================================================================
  // camera bus model, pclk period of 8 clocks
  // ==========================================================================

  task automatic send_byte(input logic [7:0] value);
    cam_data_i = value;
    cam_pclk_i = 1'b0;
    repeat (4) @(negedge clk_camera);
    cam_pclk_i = 1'b1;
    repeat (4) @(negedge clk_camera);
  endtask

  task automatic send_frame();
    // vertical blanking first
    cam_vsync_i = 1'b1;
    repeat (16) @(negedge clk_camera);
    cam_vsync_i = 1'b0;
    repeat (4) @(negedge clk_camera);
    for (int line = 0; line < FRAME_HEIGHT; line++) begin
      cam_hsync_i = 1'b1;
      for (int x = 0; x < FRAME_WIDTH; x++) begin
        send_byte(frame_pix[line * FRAME_WIDTH + x][15:8]);
        send_byte(frame_pix[line * FRAME_WIDTH + x][7:0]);
      end
      // hsync fall closes the line
      cam_pclk_i  = 1'b0;
      cam_hsync_i = 1'b0;
      repeat (8) @(negedge clk_camera);
    end
  endtask

  // fill a frame, queue the chunks that should reach the output, send it
  task automatic run_frame(input bit directed, input int delivered);
    logic [7:0] hi;
    for (int p = 0; p < FRAME_PIXELS; p++) begin
      byte_state   = lcg_next(byte_state);
      hi           = byte_state[23:16];
      byte_state   = lcg_next(byte_state);
      frame_pix[p] = {hi, byte_state[23:16]};
    end
    if (directed) begin
      // green 0, 64 and 68 once widened
      frame_pix[0] = {5'h1f, 6'd0, 5'h1f};
      frame_pix[1] = {5'h1f, 6'd16, 5'h1f};
      frame_pix[2] = {5'h1f, 6'd17, 5'h1f};
    end
    for (int c = 0; c < delivered; c++) begin
      exp_data_q.push_back(ref_chunk(8 * c));
      exp_last_q.push_back(c == CHUNKS_PER_FRAME - 1);
    end
    send_frame();
  endtask

  task automatic wait_drained();
    while (exp_data_q.size() != 0) begin
      @(posedge clk_camera);
    end
    @(negedge clk_camera);
  endtask

  // mode changes land between edges the ready driver uses
  task automatic set_ready_mode(input int mode);
    @(posedge clk_camera);
    ready_mode = mode;
    @(negedge clk_camera);
  endtask

  // ==========================================================================
  // ready driver and compare process
  // ==========================================================================

  always @(negedge clk_camera) begin
    if (ready_mode == READY_HIGH) begin
      chunk_ready_i = 1'b1;
    end else if (ready_mode == READY_LOW) begin
      chunk_ready_i = 1'b0;
    end else if (ready_left == 0) begin
      ready_state   = lcg_next(ready_state);
      chunk_ready_i = ~chunk_ready_i;
      // low stretches stay at 90 cycles or less
      if (chunk_ready_i) begin
        ready_left = 1 + int'(ready_state[19:16]);
      end else begin
        ready_left = 1 + int'(ready_state[22:16]) % 90;
      end
    end else begin
      ready_left = ready_left - 1;
    end
  end

  // a transfer is valid and ready at the same rising edge
  always @(posedge clk_camera) begin
    if (!recent_reset && chunk_valid_o && chunk_ready_i) begin
      if (exp_data_q.size() == 0) begin
        $display("a chunk arrived at %0t ns when none was expected", $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "extra chunk");
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_last = exp_last_q.pop_front();
        check_value("chunk data", chunk_data_o, exp_data);
        check_value("chunk last", 128'(chunk_last_o), 128'(exp_last));
      end
    end
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    recent_reset  = 1'b1;
    cam_data_i    = 8'h00;
    cam_pclk_i    = 1'b0;
    cam_hsync_i   = 1'b0;
    cam_vsync_i   = 1'b0;
    chunk_ready_i = 1'b1;
    repeat (10) @(negedge clk_camera);
    recent_reset = 1'b0;
    repeat (4) @(negedge clk_camera);

    // quiet outputs before any bus activity
    check_value("valid after reset", 128'(chunk_valid_o), 128'd0);
    check_value("last after reset", 128'(chunk_last_o), 128'd0);
    check_value("overflow after reset", 128'(overflow_o), 128'd0);

    // two random frames, eight chunks each, last on the eighth
    for (int f = 0; f < 2; f++) begin
      run_frame(1'b0, CHUNKS_PER_FRAME);
      wait_drained();
    end

    // window edges: fill, fill, unchanged
    run_frame(1'b1, CHUNKS_PER_FRAME);
    wait_drained();

    // random back-pressure below the drop threshold
    set_ready_mode(READY_RANDOM);
    run_frame(1'b0, CHUNKS_PER_FRAME);
    wait_drained();
    check_value("overflow under toggling ready", 128'(overflow_o), 128'd0);
    set_ready_mode(READY_HIGH);

    // ready held low, only the first chunk survives
    set_ready_mode(READY_LOW);
    run_frame(1'b0, 1);
    repeat (16) @(negedge clk_camera);
    check_value("overflow after stall", 128'(overflow_o), 128'd1);
    check_value("held chunk valid", 128'(chunk_valid_o), 128'd1);
    set_ready_mode(READY_HIGH);
    wait_drained();
    repeat (20) @(negedge clk_camera);
    check_value("valid after drain", 128'(chunk_valid_o), 128'd0);
    check_value("overflow stays set", 128'(overflow_o), 128'd1);

    if (exp_data_q.size() != 0 || dut_i.stacker_i.assertions_i.fail_count != 0) begin
      $display("expected chunks left over or an assertion failed");
      $display("SOME TESTS FAILED");
      $fatal(1, "end of run check");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
